/* compile.f */
+incdir+hdl
hdl/gteRegs_pkg.sv
hdl/screenFifo.sv
hdl/colorFifo.sv
hdl/leadSignCount.sv
hdl/irBankReadout.sv
hdl/gteDataRegs.sv
test/gteDataRegs_chk.sv
test/gteDataRegs_tb.sv

/* hdl/colorFifo.sv */
// Colour FIFO RGB0..RGB2 plus the RGBC colour/code cache
// Each channel shifts on its own push, code byte moves with blue
`timescale 1ns/10ps
`default_nettype none

`include "gteRegs_consts.svh"

module colorFifo import gteRegs_pkg::*; (
	input  wire logic                    i_clk,
	input  wire logic                    i_arstN,
	input  wire logic [`GTE_REGID_W-1:0] i_regId,
	input  wire logic                    i_wrReg,
	input  wire dataWord_u               i_dataIn,
	input  wire logic                    i_pushR,
	input  wire logic                    i_pushG,
	input  wire logic                    i_pushB,
	input  wire logic [`GTE_CHAN_W-1:0]  i_colV,
	output color_s                       o_rgb0,
	output color_s                       o_rgb1,
	output color_s                       o_rgb2,
	output color_s                       o_rgbc
);

	localparam int RegIdW = `GTE_REGID_W;
	localparam int ChanW  = `GTE_CHAN_W;
	localparam int Depth  = 3;              // RGB0..RGB2

	// Byte 0 = r, 1 = g, 2 = b, 3 = code, same order as color_s
	logic [3:0][ChanW-1:0] ent [Depth];
	color_s                rgbc;

	logic [Depth-1:0]      wrRgb;
	logic                  wrRgbc;
	logic [3:0]            chanPush;
	logic [3:0][ChanW-1:0] newest;

	always_comb begin
		for (int k = 0; k < Depth; k++) begin
			wrRgb[k] = i_wrReg && (i_regId == RegIdW'(`GTE_DR_RGB0 + k));
		end
	end

	assign wrRgbc   = i_wrReg && (i_regId == RegIdW'(`GTE_DR_RGBC));
	assign chanPush = {i_pushB, i_pushB, i_pushG, i_pushR};     // Code rides with blue
	assign newest   = {rgbc.code, i_colV, i_colV, i_colV};      // Code from the cache

	// ------------------------------------------------------------------
	// Per channel shift, CPU writes whole words
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			for (int k = 0; k < Depth; k++) begin
				ent[k] <= '0;
			end
			rgbc <= '0;
		end else begin
			for (int c = 0; c < 4; c++) begin
				for (int k = 0; k < Depth - 1; k++) begin
					if (chanPush[c])   ent[k][c] <= ent[k+1][c];
					else if (wrRgb[k]) ent[k][c] <= i_dataIn.raw[c*ChanW +: ChanW];
				end
				if (chanPush[c])           ent[Depth-1][c] <= newest[c];
				else if (wrRgb[Depth-1])   ent[Depth-1][c] <= i_dataIn.raw[c*ChanW +: ChanW];
			end
			if (wrRgbc) rgbc <= i_dataIn.col;
		end
	end

	assign o_rgb0 = ent[0];
	assign o_rgb1 = ent[1];
	assign o_rgb2 = ent[2];
	assign o_rgbc = rgbc;

endmodule

`default_nettype wire

/* hdl/gteDataRegs.sv */
// GTE data register file as seen from the CPU
// Write strobe with combinational read, one-cycle write-back strobes, no back-pressure
`timescale 1ns/10ps
`default_nettype none

`include "gteRegs_consts.svh"

module gteDataRegs import gteRegs_pkg::*; (
	input  wire logic                    i_clk,
	input  wire logic                    i_arstN,

	// CPU port
	input  wire logic [`GTE_REGID_W-1:0] i_regId,
	input  wire logic                    i_wrReg,
	input  wire dataWord_u               i_dataIn,
	output dataWord_u                    o_dataOut,

	// Coprocessor write-back
	input  wire logic                    i_pushX,
	input  wire logic                    i_pushY,
	input  wire logic                    i_pushZ,
	input  wire coord_t                  i_xyV,
	input  wire coord_t                  i_otzV,
	input  wire logic                    i_pushR,
	input  wire logic                    i_pushG,
	input  wire logic                    i_pushB,
	input  wire logic [`GTE_CHAN_W-1:0]  i_colV,
	input  wire logic [3:0]              i_wrIr,
	input  wire coord_t                  i_ir0V,
	input  wire coord_t                  i_ir13V
);

	// FIFO contents toward the read mux
	screenXy_s sxy0, sxy1, sxy2;
	coord_t    sz0, sz1, sz2, sz3;
	color_s    rgb0, rgb1, rgb2, rgbc;

	screenFifo instScreen (
		.i_clk    (i_clk),   .i_arstN  (i_arstN),
		.i_regId  (i_regId), .i_wrReg  (i_wrReg), .i_dataIn (i_dataIn),
		.i_pushX  (i_pushX), .i_pushY  (i_pushY), .i_pushZ  (i_pushZ),
		.i_xyV    (i_xyV),   .i_otzV   (i_otzV),
		.o_sxy0   (sxy0),    .o_sxy1   (sxy1),    .o_sxy2   (sxy2),
		.o_sz0    (sz0),     .o_sz1    (sz1),     .o_sz2    (sz2),    .o_sz3 (sz3)
	);

	colorFifo instColor (
		.i_clk    (i_clk),   .i_arstN  (i_arstN),
		.i_regId  (i_regId), .i_wrReg  (i_wrReg), .i_dataIn (i_dataIn),
		.i_pushR  (i_pushR), .i_pushG  (i_pushG), .i_pushB  (i_pushB),
		.i_colV   (i_colV),
		.o_rgb0   (rgb0),    .o_rgb1   (rgb1),    .o_rgb2   (rgb2),   .o_rgbc (rgbc)
	);

	// IR bank and the read side of every register
	irBankReadout instReadout (
		.i_clk    (i_clk),   .i_arstN  (i_arstN),
		.i_regId  (i_regId), .i_wrReg  (i_wrReg), .i_dataIn (i_dataIn),
		.i_wrIr   (i_wrIr),  .i_ir0V   (i_ir0V),  .i_ir13V  (i_ir13V),
		.i_sxy0   (sxy0),    .i_sxy1   (sxy1),    .i_sxy2   (sxy2),
		.i_sz0    (sz0),     .i_sz1    (sz1),     .i_sz2    (sz2),    .i_sz3  (sz3),
		.i_rgb0   (rgb0),    .i_rgb1   (rgb1),    .i_rgb2   (rgb2),   .i_rgbc (rgbc),
		.o_dataOut(o_dataOut)
	);

endmodule

`default_nettype wire

/* hdl/gteRegs_consts.svh */
// Register numbers, widths and FIFO depths for the GTE data register file
// Only the data registers kept here have numbers, all others read zero
`ifndef GTEREGS_CONSTS_SVH
`define GTEREGS_CONSTS_SVH

// ----------------------------------------------------------------------
// Widths
// ----------------------------------------------------------------------
`define GTE_REGID_W     5       // CPU register number
`define GTE_DATA_W      32      // CPU data word
`define GTE_HALF_W      16      // Screen coordinate / IR value
`define GTE_CHAN_W      8       // One colour byte

// FIFO depths
`define GTE_SXY_DEPTH   3
`define GTE_SZ_DEPTH    4

// IRGB packing, 5-bit colour field sits at bit 7 of an IR value
`define GTE_IRGB_SHIFT  7
`define GTE_IRGB_MAX    31

// ----------------------------------------------------------------------
// Data register numbers
// ----------------------------------------------------------------------
`define GTE_DR_RGBC     6       // Colour/code cache

`define GTE_DR_IR0      8
`define GTE_DR_IR1      9
`define GTE_DR_IR2      10
`define GTE_DR_IR3      11

`define GTE_DR_SXY0     12
`define GTE_DR_SXY1     13
`define GTE_DR_SXY2     14
`define GTE_DR_SXYP     15      // Write pushes, read mirrors SXY2

`define GTE_DR_SZ0      16
`define GTE_DR_SZ1      17
`define GTE_DR_SZ2      18
`define GTE_DR_SZP      19      // Newest Z entry (SZ3)

`define GTE_DR_RGB0     20
`define GTE_DR_RGB1     21
`define GTE_DR_RGB2     22

`define GTE_DR_IRGB     28      // Packed colour write into IR1..IR3
`define GTE_DR_ORGB     29      // Read only, same as IRGB read
`define GTE_DR_LZCS     30      // Leading sign count source
`define GTE_DR_LZCR     31      // Leading sign count result

`endif

/* hdl/gteRegs_pkg.sv */
// Shared types of the GTE data register file
// One 32-bit CPU word is seen either as two coordinates or as four bytes
`default_nettype none

`include "gteRegs_consts.svh"

package gteRegs_pkg;

	// Signed screen coordinate, also used for IR values
	typedef logic signed [`GTE_HALF_W-1:0] coord_t;

	// SXYn layout, Y in the upper half
	typedef struct packed {
		coord_t sy;
		coord_t sx;
	} screenXy_s;

	// RGBn / RGBC layout, code byte on top
	typedef struct packed {
		logic [`GTE_CHAN_W-1:0] code;
		logic [`GTE_CHAN_W-1:0] b;
		logic [`GTE_CHAN_W-1:0] g;
		logic [`GTE_CHAN_W-1:0] r;
	} color_s;

	// CPU data word, decoded by the register it targets
	typedef union packed {
		screenXy_s              xy;
		color_s                 col;
		logic [`GTE_DATA_W-1:0] raw;
	} dataWord_u;

endpackage

`default_nettype wire

/* hdl/irBankReadout.sv */
// IR0..IR3 and LZCS registers, plus the combinational CPU read mux
// Read data follows i_regId in the same cycle, unknown numbers read zero
`timescale 1ns/10ps
`default_nettype none

`include "gteRegs_consts.svh"

module irBankReadout import gteRegs_pkg::*; (
	input  wire logic                    i_clk,
	input  wire logic                    i_arstN,
	input  wire logic [`GTE_REGID_W-1:0] i_regId,
	input  wire logic                    i_wrReg,
	input  wire dataWord_u               i_dataIn,
	input  wire logic [3:0]              i_wrIr,
	input  wire coord_t                  i_ir0V,
	input  wire coord_t                  i_ir13V,
	input  wire screenXy_s               i_sxy0,
	input  wire screenXy_s               i_sxy1,
	input  wire screenXy_s               i_sxy2,
	input  wire coord_t                  i_sz0,
	input  wire coord_t                  i_sz1,
	input  wire coord_t                  i_sz2,
	input  wire coord_t                  i_sz3,
	input  wire color_s                  i_rgb0,
	input  wire color_s                  i_rgb1,
	input  wire color_s                  i_rgb2,
	input  wire color_s                  i_rgbc,
	output dataWord_u                    o_dataOut
);

	localparam int RegIdW = `GTE_REGID_W;
	localparam int HalfW  = `GTE_HALF_W;
	localparam int PadW   = `GTE_DATA_W - `GTE_HALF_W;

	coord_t                 ir [4];
	logic [`GTE_DATA_W-1:0] lzcs;
	logic [5:0]             lzCount;
	logic [14:0]            irgbPack;       // {B5, G5, R5}
	logic [3:0]             wrIrCpu;
	logic                   wrIrgb, wrLzcs;

	// IR value to a 5-bit colour, clamped to 0..31
	function automatic logic [4:0] sat5(input coord_t v);
		coord_t q;
		q = v >>> `GTE_IRGB_SHIFT;
		if (v < 0)                   return '0;
		else if (q > `GTE_IRGB_MAX)  return 5'(`GTE_IRGB_MAX);
		else                         return q[4:0];
	endfunction

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			wrIrCpu[k] = i_wrReg && (i_regId == RegIdW'(`GTE_DR_IR0 + k));
		end
	end

	assign wrIrgb = i_wrReg && (i_regId == RegIdW'(`GTE_DR_IRGB));
	assign wrLzcs = i_wrReg && (i_regId == RegIdW'(`GTE_DR_LZCS));

	// ------------------------------------------------------------------
	// IR and LZCS registers
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			for (int k = 0; k < 4; k++) begin
				ir[k] <= '0;
			end
			lzcs <= '0;
		end else begin
			if (i_wrIr[0])       ir[0] <= i_ir0V;
			else if (wrIrCpu[0]) ir[0] <= i_dataIn.xy.sx;
			for (int k = 1; k < 4; k++) begin
				if (i_wrIr[k])       ir[k] <= i_ir13V;     // Shared IR1..IR3 value
				else if (wrIrgb)     ir[k] <= coord_t'(i_dataIn.raw[(k-1)*5 +: 5])
				                              << `GTE_IRGB_SHIFT;
				else if (wrIrCpu[k]) ir[k] <= i_dataIn.xy.sx;
			end
			if (wrLzcs) lzcs <= i_dataIn.raw;
		end
	end

	leadSignCount instLeadCount (
		.i_value (lzcs),
		.o_count (lzCount)
	);

	assign irgbPack = {sat5(ir[3]), sat5(ir[2]), sat5(ir[1])};

	// ------------------------------------------------------------------
	// CPU read mux
	// ------------------------------------------------------------------
	always_comb begin
		o_dataOut.raw = '0;
		case (i_regId)
			`GTE_DR_SXY0                : o_dataOut.xy  = i_sxy0;
			`GTE_DR_SXY1                : o_dataOut.xy  = i_sxy1;
			`GTE_DR_SXY2, `GTE_DR_SXYP  : o_dataOut.xy  = i_sxy2;     // SXYP mirrors newest
			`GTE_DR_SZ0                 : o_dataOut.raw = {{PadW{1'b0}}, i_sz0};
			`GTE_DR_SZ1                 : o_dataOut.raw = {{PadW{1'b0}}, i_sz1};
			`GTE_DR_SZ2                 : o_dataOut.raw = {{PadW{1'b0}}, i_sz2};
			`GTE_DR_SZP                 : o_dataOut.raw = {{PadW{1'b0}}, i_sz3};
			`GTE_DR_RGB0                : o_dataOut.col = i_rgb0;
			`GTE_DR_RGB1                : o_dataOut.col = i_rgb1;
			`GTE_DR_RGB2                : o_dataOut.col = i_rgb2;
			`GTE_DR_RGBC                : o_dataOut.col = i_rgbc;
			`GTE_DR_IR0                 : o_dataOut.raw = {{PadW{ir[0][HalfW-1]}}, ir[0]};
			`GTE_DR_IR1                 : o_dataOut.raw = {{PadW{ir[1][HalfW-1]}}, ir[1]};
			`GTE_DR_IR2                 : o_dataOut.raw = {{PadW{ir[2][HalfW-1]}}, ir[2]};
			`GTE_DR_IR3                 : o_dataOut.raw = {{PadW{ir[3][HalfW-1]}}, ir[3]};
			`GTE_DR_IRGB, `GTE_DR_ORGB  : o_dataOut.raw = {17'd0, irgbPack};
			`GTE_DR_LZCS                : o_dataOut.raw = lzcs;
			`GTE_DR_LZCR                : o_dataOut.raw = {26'd0, lzCount};
			default                     : o_dataOut.raw = '0;        // Dropped registers
		endcase
	end

endmodule

`default_nettype wire

/* hdl/leadSignCount.sv */
// Leading sign bit counter, result 1..32
// All-zero and all-one words give 32
`timescale 1ns/10ps
`default_nettype none

`include "gteRegs_consts.svh"

module leadSignCount (
	input  wire logic [`GTE_DATA_W-1:0] i_value,
	output logic [5:0]                  o_count
);

	localparam int DataW = `GTE_DATA_W;

	// Scan from MSB down, stop at the first bit differing from the sign
	always_comb begin
		logic run;
		logic [5:0] cnt;
		run = 1'b1;
		cnt = '0;
		for (int i = DataW - 1; i >= 0; i--) begin
			if (run && (i_value[i] == i_value[DataW-1])) begin
				cnt = cnt + 6'd1;
			end else begin
				run = 1'b0;                 // Sign run broken
			end
		end
		o_count = cnt;                      // Sign bit itself always counts
	end

endmodule

`default_nettype wire

/* hdl/screenFifo.sv */
// Screen XY FIFO (3 entries) and screen Z FIFO (4 entries)
// CPU write and coprocessor push in the same cycle is not supported
`timescale 1ns/10ps
`default_nettype none

`include "gteRegs_consts.svh"

module screenFifo import gteRegs_pkg::*; (
	input  wire logic                    i_clk,
	input  wire logic                    i_arstN,
	input  wire logic [`GTE_REGID_W-1:0] i_regId,
	input  wire logic                    i_wrReg,
	input  wire dataWord_u               i_dataIn,
	input  wire logic                    i_pushX,
	input  wire logic                    i_pushY,
	input  wire logic                    i_pushZ,
	input  wire coord_t                  i_xyV,
	input  wire coord_t                  i_otzV,
	output screenXy_s                    o_sxy0,
	output screenXy_s                    o_sxy1,
	output screenXy_s                    o_sxy2,
	output coord_t                       o_sz0,
	output coord_t                       o_sz1,
	output coord_t                       o_sz2,
	output coord_t                       o_sz3
);

	localparam int RegIdW = `GTE_REGID_W;
	localparam int XyD    = `GTE_SXY_DEPTH;
	localparam int ZD     = `GTE_SZ_DEPTH;

	coord_t sx [XyD];           // Entry 0 is oldest
	coord_t sy [XyD];
	coord_t sz [ZD];

	logic [XyD-1:0] wrSxy;      // Direct CPU writes SXY0..SXY2
	logic [ZD-1:0]  wrSz;       // SZ0..SZ2, top bit is SZP
	logic           wrSxyp;
	logic           shiftX, shiftY;
	coord_t         newX, newY;

	// ------------------------------------------------------------------
	// Register decode
	// ------------------------------------------------------------------
	always_comb begin
		for (int k = 0; k < XyD; k++) begin
			wrSxy[k] = i_wrReg && (i_regId == RegIdW'(`GTE_DR_SXY0 + k));
		end
		for (int k = 0; k < ZD - 1; k++) begin
			wrSz[k] = i_wrReg && (i_regId == RegIdW'(`GTE_DR_SZ0 + k));
		end
		wrSz[ZD-1] = i_wrReg && (i_regId == RegIdW'(`GTE_DR_SZP));
	end

	assign wrSxyp = i_wrReg && (i_regId == RegIdW'(`GTE_DR_SXYP));
	assign shiftX = i_pushX | wrSxyp;       // SXYP write pushes both halves
	assign shiftY = i_pushY | wrSxyp;
	assign newX   = i_wrReg ? i_dataIn.xy.sx : i_xyV;
	assign newY   = i_wrReg ? i_dataIn.xy.sy : i_xyV;

	// ------------------------------------------------------------------
	// FIFO storage
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			for (int k = 0; k < XyD; k++) begin
				sx[k] <= '0;
				sy[k] <= '0;
			end
			for (int k = 0; k < ZD; k++) begin
				sz[k] <= '0;
			end
		end else begin
			for (int k = 0; k < XyD - 1; k++) begin
				if (shiftX)        sx[k] <= sx[k+1];        // Shift toward oldest
				else if (wrSxy[k]) sx[k] <= i_dataIn.xy.sx;
				if (shiftY)        sy[k] <= sy[k+1];
				else if (wrSxy[k]) sy[k] <= i_dataIn.xy.sy;
			end
			if (shiftX)              sx[XyD-1] <= newX;
			else if (wrSxy[XyD-1])   sx[XyD-1] <= i_dataIn.xy.sx;
			if (shiftY)              sy[XyD-1] <= newY;
			else if (wrSxy[XyD-1])   sy[XyD-1] <= i_dataIn.xy.sy;

			// Z shifts only on coprocessor push, SZP write does not shift
			for (int k = 0; k < ZD - 1; k++) begin
				if (i_pushZ)      sz[k] <= sz[k+1];
				else if (wrSz[k]) sz[k] <= i_dataIn.xy.sx;   // Low half
			end
			if (i_pushZ)         sz[ZD-1] <= i_otzV;
			else if (wrSz[ZD-1]) sz[ZD-1] <= i_dataIn.xy.sx;
		end
	end

	assign o_sxy0 = {sy[0], sx[0]};
	assign o_sxy1 = {sy[1], sx[1]};
	assign o_sxy2 = {sy[2], sx[2]};
	assign o_sz0  = sz[0];
	assign o_sz1  = sz[1];
	assign o_sz2  = sz[2];
	assign o_sz3  = sz[3];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then judge the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module gteDataRegs_tb -f compile.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "^sim passed$" sim.log; then
	echo "RESULT: PASS"
	exit 0
fi
echo "RESULT: FAIL"
exit 1

/* test/gteDataRegs_chk.sv */
// Concurrent checks on the data register file, bound into gteDataRegs
// Kept register numbers are 6, 8..22 and 28..31, all others must read zero
`timescale 1ns/10ps
`default_nettype none

`include "gteRegs_consts.svh"

module gteDataRegs_chk (
	input wire logic                    i_clk,
	input wire logic                    i_arstN,
	input wire logic [`GTE_REGID_W-1:0] i_regId,
	input wire logic                    i_wrReg,
	input wire logic                    i_pushX,
	input wire logic                    i_pushY,
	input wire logic                    i_pushZ,
	input wire logic                    i_pushR,
	input wire logic                    i_pushG,
	input wire logic                    i_pushB,
	input wire logic [3:0]              i_wrIr,
	input wire logic [`GTE_DATA_W-1:0]  i_dataOut
);

	logic anyWb;        // Any write-back strobe
	logic kept;         // Register number has storage behind it

	assign anyWb = i_pushX | i_pushY | i_pushZ | i_pushR | i_pushG | i_pushB | (|i_wrIr);
	assign kept  = (i_regId == 5'(`GTE_DR_RGBC))
	            || (i_regId >= 5'(`GTE_DR_IR0) && i_regId <= 5'(`GTE_DR_RGB2))
	            || (i_regId >= 5'(`GTE_DR_IRGB));

	// ----------------------------------------------------------------------
	// Properties
	// ----------------------------------------------------------------------
	noWriteCollision: assert property (@(posedge i_clk) disable iff (!i_arstN)
		i_wrReg |-> !anyWb)
		else $error("CPU write and write-back strobe in the same cycle");

	zeroAfterReset: assert property (@(posedge i_clk)
		$rose(i_arstN) |-> i_dataOut == '0)
		else $error("read data not zero right after reset release");

	zeroUnused: assert property (@(posedge i_clk) disable iff (!i_arstN)
		!kept |-> i_dataOut == '0)
		else $error("unused register number returned nonzero data");

endmodule

bind gteDataRegs gteDataRegs_chk instChk (
	.i_clk    (i_clk),
	.i_arstN  (i_arstN),
	.i_regId  (i_regId),
	.i_wrReg  (i_wrReg),
	.i_pushX  (i_pushX),
	.i_pushY  (i_pushY),
	.i_pushZ  (i_pushZ),
	.i_pushR  (i_pushR),
	.i_pushG  (i_pushG),
	.i_pushB  (i_pushB),
	.i_wrIr   (i_wrIr),
	.i_dataOut(o_dataOut)
);

`default_nettype wire

/* test/gteDataRegs_tb.sv */
// Directed tests for gteDataRegs against a register-level reference model
// Inputs change on the falling edge, reads are sampled 5 ns later
`timescale 1ns/10ps
`default_nettype none

`include "gteRegs_consts.svh"

module gteDataRegs_tb import gteRegs_pkg::*; ();

	localparam int HalfPeriod = 20;
	localparam int PollLimit  = 200;        // ns allowed per clock edge

	logic                    i_clk = 1'b0;
	logic                    i_arstN;
	logic [`GTE_REGID_W-1:0] i_regId;
	logic                    i_wrReg;
	dataWord_u               i_dataIn;
	dataWord_u               o_dataOut;
	logic                    i_pushX, i_pushY, i_pushZ;
	logic                    i_pushR, i_pushG, i_pushB;
	coord_t                  i_xyV, i_otzV, i_ir0V, i_ir13V;
	logic [`GTE_CHAN_W-1:0]  i_colV;
	logic [3:0]              i_wrIr;

	// ----------------------------------------------------------------------
	// Reference model, entry 0 oldest
	// ----------------------------------------------------------------------
	logic [15:0] mSx [3];
	logic [15:0] mSy [3];
	logic [15:0] mSz [4];
	logic [15:0] mIr [4];
	logic [31:0] mRgb [3];
	logic [31:0] mRgbc, mLzcs;

	gteDataRegs i_dut (.*);

	always #(HalfPeriod) i_clk = ~i_clk;

	task automatic failRun(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("sim failed");
		$fatal(1, "run aborted");
	endtask

	task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("sim failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// Polled wait for the next falling edge
	task automatic nextFall();
		int ticks;
		ticks = 0;
		while (i_clk !== 1'b1 && ticks < PollLimit) begin
			#1;
			ticks++;
		end
		while (i_clk !== 1'b0 && ticks < PollLimit) begin
			#1;
			ticks++;
		end
		if (ticks >= PollLimit) failRun("clock stopped toggling");
	endtask

	task automatic clearStrobes();
		i_wrReg = 1'b0;
		{i_pushX, i_pushY, i_pushZ} = 3'b000;
		{i_pushR, i_pushG, i_pushB} = 3'b000;
		i_wrIr  = 4'h0;
	endtask

	// Saturated 5-bit colour of an IR value
	function automatic logic [4:0] expSat(input logic [15:0] v);
		int q;
		q = int'(v) / 128;                  // Only used for v >= 0
		if (v[15]) return 5'd0;
		return (q > 31) ? 5'd31 : q[4:0];
	endfunction

	// Number of leading bits equal to the sign
	function automatic logic [5:0] expLead(input logic [31:0] w);
		int n;
		n = 1;
		while (n < 32 && w[31-n] == w[31]) n++;
		return 6'(n);
	endfunction

	function automatic void shiftXy(input bit px, input bit py, input logic [15:0] x,
	                                input logic [15:0] y);
		if (px) begin
			mSx[0] = mSx[1];
			mSx[1] = mSx[2];
			mSx[2] = x;
		end
		if (py) begin
			mSy[0] = mSy[1];
			mSy[1] = mSy[2];
			mSy[2] = y;
		end
	endfunction

	function automatic void shiftChan(input int c, input logic [7:0] v);
		mRgb[0][c*8 +: 8] = mRgb[1][c*8 +: 8];
		mRgb[1][c*8 +: 8] = mRgb[2][c*8 +: 8];
		mRgb[2][c*8 +: 8] = v;
	endfunction

	function automatic logic [31:0] expRead(input logic [4:0] id);
		int n;
		n = int'(id);
		case (n)
			`GTE_DR_RGBC: return mRgbc;
			`GTE_DR_IR0, `GTE_DR_IR1, `GTE_DR_IR2, `GTE_DR_IR3:
				return {{16{mIr[n - `GTE_DR_IR0][15]}}, mIr[n - `GTE_DR_IR0]};
			`GTE_DR_SXY0, `GTE_DR_SXY1, `GTE_DR_SXY2:
				return {mSy[n - `GTE_DR_SXY0], mSx[n - `GTE_DR_SXY0]};
			`GTE_DR_SXYP: return {mSy[2], mSx[2]};      // Newest XY entry
			`GTE_DR_SZ0, `GTE_DR_SZ1, `GTE_DR_SZ2, `GTE_DR_SZP:
				return {16'h0, mSz[n - `GTE_DR_SZ0]};
			`GTE_DR_RGB0, `GTE_DR_RGB1, `GTE_DR_RGB2: return mRgb[n - `GTE_DR_RGB0];
			`GTE_DR_IRGB, `GTE_DR_ORGB:
				return {17'h0, expSat(mIr[3]), expSat(mIr[2]), expSat(mIr[1])};
			`GTE_DR_LZCS: return mLzcs;
			`GTE_DR_LZCR: return {26'h0, expLead(mLzcs)};
			default:      return 32'h0;
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// Bus actions
	// ----------------------------------------------------------------------
	task automatic cpuWrite(input logic [4:0] id, input logic [31:0] d);
		int n;
		n = int'(id);
		nextFall();
		i_regId      = id;
		i_dataIn.raw = d;
		i_wrReg      = 1'b1;
		nextFall();
		i_wrReg      = 1'b0;
		case (n)
			`GTE_DR_SXY0, `GTE_DR_SXY1, `GTE_DR_SXY2: begin
				mSx[n - `GTE_DR_SXY0] = d[15:0];
				mSy[n - `GTE_DR_SXY0] = d[31:16];
			end
			`GTE_DR_SXYP: shiftXy(1'b1, 1'b1, d[15:0], d[31:16]);
			`GTE_DR_SZ0, `GTE_DR_SZ1, `GTE_DR_SZ2, `GTE_DR_SZP: mSz[n - `GTE_DR_SZ0] = d[15:0];
			`GTE_DR_RGB0, `GTE_DR_RGB1, `GTE_DR_RGB2: mRgb[n - `GTE_DR_RGB0] = d;
			`GTE_DR_RGBC: mRgbc = d;
			`GTE_DR_IR0, `GTE_DR_IR1, `GTE_DR_IR2, `GTE_DR_IR3: mIr[n - `GTE_DR_IR0] = d[15:0];
			`GTE_DR_IRGB: begin
				for (int k = 1; k < 4; k++) mIr[k] = {4'h0, d[(k-1)*5 +: 5], 7'h0};
			end
			`GTE_DR_LZCS: mLzcs = d;
			default: ;
		endcase
	endtask

	// One-cycle write-back, a feeds XY, colour and IR0, b feeds Z and IR1..IR3
	task automatic writeBack(input logic [2:0] xyz, input logic [2:0] rgb,
	                         input logic [3:0] irMask, input logic [15:0] a,
	                         input logic [15:0] b);
		nextFall();
		{i_pushZ, i_pushY, i_pushX} = xyz;
		{i_pushB, i_pushG, i_pushR} = rgb;
		i_wrIr  = irMask;
		i_xyV   = a;
		i_ir0V  = a;
		i_colV  = a[7:0];
		i_otzV  = b;
		i_ir13V = b;
		nextFall();
		clearStrobes();
		shiftXy(xyz[0], xyz[1], a, a);
		if (xyz[2]) begin
			for (int k = 0; k < 3; k++) mSz[k] = mSz[k+1];
			mSz[3] = b;
		end
		if (rgb[2]) shiftChan(3, mRgbc[31:24]);     // Code byte follows blue
		for (int c = 0; c < 3; c++) if (rgb[c]) shiftChan(c, a[7:0]);
		if (irMask[0]) mIr[0] = a;
		for (int k = 1; k < 4; k++) if (irMask[k]) mIr[k] = b;
	endtask

	task automatic readCheck(input logic [4:0] id);
		nextFall();
		i_regId = id;
		#5;
		compare(o_dataOut.raw, expRead(id), $sformatf("read of register %0d", id));
	endtask

	task automatic checkAll();
		for (int id = 0; id < 32; id++) readCheck(5'(id));
	endtask

	// ----------------------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------------------
	task automatic testCpuWrites();
		int ids [16];
		ids = '{`GTE_DR_RGBC, `GTE_DR_IR0, `GTE_DR_IR1, `GTE_DR_IR2, `GTE_DR_IR3,
		        `GTE_DR_SXY0, `GTE_DR_SXY1, `GTE_DR_SXY2, `GTE_DR_SZ0, `GTE_DR_SZ1,
		        `GTE_DR_SZ2, `GTE_DR_SZP, `GTE_DR_RGB0, `GTE_DR_RGB1, `GTE_DR_RGB2,
		        `GTE_DR_LZCS};
		for (int k = 0; k < 16; k++) begin
			cpuWrite(5'(ids[k]), $urandom());
			readCheck(5'(ids[k]));
		end
		checkAll();                         // SXYP, LZCR and cross effects
	endtask

	task automatic testScreenPush();
		int pick;
		for (int k = 0; k < 10; k++) begin
			pick = $urandom_range(3, 0);
			if (pick == 0) cpuWrite(`GTE_DR_SXYP, $urandom());
			else if (pick == 1) cpuWrite(`GTE_DR_SZP, $urandom());      // No shift
			else writeBack(3'($urandom_range(7, 1)), 3'b000, 4'h0, 16'($urandom()),
			               16'($urandom()));
			checkAll();
		end
	endtask

	task automatic testColorPush();
		for (int k = 0; k < 12; k++) begin
			if (k % 4 == 0) cpuWrite(`GTE_DR_RGBC, $urandom());   // New code byte
			writeBack(3'b000, 3'($urandom_range(7, 1)), 4'h0, 16'($urandom()), 16'h0);
			checkAll();
		end
	endtask

	task automatic testIrgb();
		cpuWrite(`GTE_DR_IRGB, $urandom());
		checkAll();
		writeBack(3'b000, 3'b000, 4'hf, 16'hff00, 16'h8001);     // All negative
		checkAll();
		writeBack(3'b000, 3'b000, 4'h2, 16'h0, 16'h7fff);        // Far above 31
		writeBack(3'b000, 3'b000, 4'h4, 16'h0, 16'h0f80);        // Exactly 31
		writeBack(3'b000, 3'b000, 4'h8, 16'h0, 16'h1000);        // 32, clamps
		checkAll();
	endtask

	task automatic testLeadSign();
		logic [31:0] vals [$];
		vals = '{32'h0, 32'hffffffff, 32'h1, 32'h80000000, 32'h7fffffff};
		for (int k = 0; k < 8; k++) vals.push_back($urandom() >> $urandom_range(31, 0));
		vals.push_back(~($urandom() >> 12));
		foreach (vals[k]) begin
			cpuWrite(`GTE_DR_LZCS, vals[k]);
			readCheck(`GTE_DR_LZCR);
		end
	endtask

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------
	initial begin
		void'($urandom(32'h3293));
		i_arstN = 1'b0;
		i_regId = 5'(`GTE_DR_SXY2);         // Kept register across reset release
		i_dataIn = '0;
		{i_xyV, i_otzV, i_ir0V, i_ir13V} = '0;
		i_colV = '0;
		clearStrobes();
		for (int k = 0; k < 4; k++) mIr[k] = '0;
		for (int k = 0; k < 4; k++) mSz[k] = '0;
		for (int k = 0; k < 3; k++) begin
			mSx[k]  = '0;
			mSy[k]  = '0;
			mRgb[k] = '0;
		end
		mRgbc = '0;
		mLzcs = '0;

		repeat (5) nextFall();              // Reset held 5 cycles
		i_arstN = 1'b1;

		checkAll();                         // Everything reads zero after reset
		testCpuWrites();
		testScreenPush();
		testColorPush();
		testIrgb();
		testLeadSign();

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
